//--- design/uart_pkg.sv
package uart_pkg;

    // Payload and FIFO sizing
    localparam int uart_data_width = 8;
    localparam int uart_fifo_depth = 8;
    localparam int uart_cnt_width  = 4;
    localparam int uart_th_width   = 3;

    // Baud divisor where one bit period is div+1 clocks
    localparam int uart_div_width = 16;
    localparam logic [uart_div_width-1:0] uart_div_reset = 16'd433;

    // Flops on the serial input before the receiver
    localparam int uart_n_sync = 2;

    // Register offsets
    localparam logic [11:0] uart_txfifo = 12'h000;
    localparam logic [11:0] uart_rxfifo = 12'h004;
    localparam logic [11:0] uart_txctrl = 12'h008;
    localparam logic [11:0] uart_rxctrl = 12'h00C;
    localparam logic [11:0] uart_ie     = 12'h010;
    localparam logic [11:0] uart_ip     = 12'h014;
    localparam logic [11:0] uart_ic     = 12'h018;
    localparam logic [11:0] uart_div    = 12'h01C;
    localparam logic [11:0] uart_lcr    = 12'h020;

endpackage

//--- design/uart_fifo.sv
`timescale 1ns/100ps

module uart_fifo (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                push,
    input  logic [uart_pkg::uart_data_width-1:0] wdata,
    input  logic                                pop,
    output logic [uart_pkg::uart_data_width-1:0] rdata,
    output logic                                full,
    output logic                                empty,
    output logic [uart_pkg::uart_cnt_width-1:0]  count,
    input  logic [uart_pkg::uart_th_width-1:0]   th,
    output logic                                above_th,
    output logic                                below_th
);

    import uart_pkg::*;

    logic [uart_data_width-1:0]         mem [uart_fifo_depth];
    logic [$clog2(uart_fifo_depth)-1:0] wptr;
    logic [$clog2(uart_fifo_depth)-1:0] rptr;
    logic                               do_push;
    logic                               do_pop;

    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;
    assign rdata    = mem[rptr];
    assign full     = (count == uart_cnt_width'(uart_fifo_depth));
    assign empty    = (count == '0);
    assign above_th = (count >  {1'b0, th});
    assign below_th = (count <= {1'b0, th});

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wptr <= wptr + 1'b1;
            if (do_pop)
                rptr <= rptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wptr] <= wdata;
    end

    a_count_le_depth: assert property (@(posedge clk) disable iff (!rstn)
        count <= uart_cnt_width'(uart_fifo_depth));
    a_ptr_gap_is_count: assert property (@(posedge clk) disable iff (!rstn)
        (wptr - rptr) == count[$clog2(uart_fifo_depth)-1:0]);

endmodule

//--- design/baud_timer.sv
`timescale 1ns/100ps

module baud_timer (
    input  logic                               clk,
    input  logic                               rstn,
    input  logic                               start,
    input  logic [uart_pkg::uart_div_width-1:0] div,
    output logic                               tick,
    output logic                               mid
);

    import uart_pkg::*;

    logic [uart_div_width-1:0] cnt;

    // Both strobes are quiet while the owner holds the timer in load
    assign tick = !start && (cnt == '0);
    assign mid  = !start && (cnt == (div >> 1));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (start || cnt == '0) begin
            cnt <= div;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- design/uart_tx_fsm.sv
`timescale 1ns/100ps

module uart_tx_fsm (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                enable,
    input  logic                                parity_en,
    input  logic                                nstop,
    input  logic                                data_vld,
    input  logic [uart_pkg::uart_data_width-1:0] data_in,
    output logic                                pop,
    input  logic                                tick,
    output logic                                timer_start,
    output logic                                uart_tx
);

    import uart_pkg::*;

    typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} state_t;

    state_t                             state;
    state_t                             state_nxt;
    logic [$clog2(uart_data_width)-1:0] bit_cnt;
    logic [uart_data_width-1:0]         shift;
    logic                               par;
    logic                               line_nxt;

    assign pop         = (state == st_idle) && enable && data_vld;
    assign timer_start = (state == st_idle);

    // Line value is computed for the next state so uart_tx stays registered
    always_comb begin
        state_nxt = state;
        line_nxt  = uart_tx;
        case (state)
            st_idle: begin
                if (pop) begin
                    state_nxt = st_start;
                    line_nxt  = 1'b0;
                end
            end
            st_start: begin
                if (tick) begin
                    state_nxt = st_data;
                    line_nxt  = shift[0];
                end
            end
            st_data: begin
                if (tick) begin
                    if (bit_cnt == $bits(bit_cnt)'(uart_data_width - 1)) begin
                        state_nxt = parity_en ? st_parity : st_stop;
                        line_nxt  = parity_en ? par : 1'b1;
                    end else begin
                        line_nxt = shift[0];
                    end
                end
            end
            st_parity: begin
                if (tick) begin
                    state_nxt = st_stop;
                    line_nxt  = 1'b1;
                end
            end
            st_stop: begin
                if (tick && bit_cnt == {{($bits(bit_cnt)-1){1'b0}}, nstop})
                    state_nxt = st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= st_idle;
            uart_tx <= 1'b1;
            bit_cnt <= '0;
        end else begin
            state   <= state_nxt;
            uart_tx <= line_nxt;
            if (pop)
                bit_cnt <= '0;
            else if (tick && (state == st_data || state == st_stop))
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Even-sum parity over the data bits
    always_ff @(posedge clk) begin
        if (pop) begin
            shift <= data_in;
            par   <= ^data_in;
        end else if (tick && (state == st_start || state == st_data)) begin
            shift <= {1'b0, shift[uart_data_width-1:1]};
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rstn)
        (state == st_idle) |-> uart_tx);

endmodule

//--- design/uart_rx_fsm.sv
`timescale 1ns/100ps

module uart_rx_fsm (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                enable,
    input  logic                                parity_en,
    input  logic                                uart_rx,
    input  logic                                tick,
    input  logic                                mid,
    output logic                                timer_start,
    output logic                                push,
    output logic [uart_pkg::uart_data_width-1:0] data_out,
    output logic                                perror
);

    import uart_pkg::*;

    typedef enum logic [2:0] {
        st_idle, st_start, st_data, st_parity, st_stop, st_error
    } state_t;

    state_t                             state;
    state_t                             state_nxt;
    logic [uart_n_sync-1:0]             sync;
    logic                               rx_s;
    logic [$clog2(uart_data_width)-1:0] bit_cnt;
    logic                               par_bit;
    logic                               par_bad;

    assign rx_s        = sync[uart_n_sync-1];
    assign timer_start = (state == st_idle);
    assign par_bad     = parity_en && (^data_out ^ par_bit);

    always_comb begin
        state_nxt = state;
        push      = 1'b0;
        perror    = 1'b0;
        case (state)
            st_idle: begin
                if (enable && !rx_s)
                    state_nxt = st_start;
            end
            st_start: begin
                // A start bit that is high again at mid-bit was a glitch
                if (mid && rx_s)
                    state_nxt = st_error;
                else if (tick)
                    state_nxt = st_data;
            end
            st_data: begin
                if (tick && bit_cnt == $bits(bit_cnt)'(uart_data_width - 1))
                    state_nxt = parity_en ? st_parity : st_stop;
            end
            st_parity: begin
                if (tick)
                    state_nxt = st_stop;
            end
            st_stop: begin
                if (mid) begin
                    if (!rx_s) begin
                        state_nxt = st_error;
                    end else begin
                        push      = !par_bad;
                        perror    = par_bad;
                        state_nxt = st_idle;
                    end
                end
            end
            st_error: begin
                // Wait for the line to return high before hunting again
                if (rx_s)
                    state_nxt = st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync    <= '1;
            state   <= st_idle;
            bit_cnt <= '0;
        end else begin
            sync  <= {sync[uart_n_sync-2:0], uart_rx};
            state <= state_nxt;
            if (state == st_idle)
                bit_cnt <= '0;
            else if (state == st_data && tick)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // New bits enter at the top because the line is LSB first
    always_ff @(posedge clk) begin
        if (state == st_data && mid)
            data_out <= {rx_s, data_out[uart_data_width-1:1]};
        if (state == st_parity && mid)
            par_bit <= rx_s;
    end

    a_push_data_known: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !$isunknown(data_out));

endmodule

//--- design/uart_regs.sv
`timescale 1ns/100ps

module uart_regs (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [11:0]                         paddr,
    input  logic [31:0]                         pwdata,
    output logic [31:0]                         prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                tx_push,
    output logic [uart_pkg::uart_data_width-1:0] tx_wdata,
    input  logic                                tx_full,
    output logic                                rx_pop,
    input  logic [uart_pkg::uart_data_width-1:0] rx_rdata,
    input  logic                                rx_empty,
    input  logic                                tx_below_th,
    input  logic                                rx_above_th,
    input  logic                                rx_perror,
    output logic                                tx_en,
    output logic                                rx_en,
    output logic                                nstop,
    output logic                                parity_en,
    output logic [uart_pkg::uart_div_width-1:0]  div,
    output logic [uart_pkg::uart_th_width-1:0]   tx_th,
    output logic [uart_pkg::uart_th_width-1:0]   rx_th,
    output logic                                irq_out
);

    import uart_pkg::*;

    logic        apb_wr;
    logic        apb_rd;
    logic [2:0]  ie;
    logic [2:0]  ip;
    logic [2:0]  ip_clr;
    logic [31:0] rdata_mux;

    // Transfers are taken in the setup phase
    assign apb_wr  = psel && !penable && pwrite;
    assign apb_rd  = psel && !penable && !pwrite;
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign tx_push  = apb_wr && paddr == uart_txfifo && !tx_full && !pwdata[31];
    assign tx_wdata = pwdata[uart_data_width-1:0];
    assign rx_pop   = apb_rd && paddr == uart_rxfifo && !rx_empty;

    assign ip_clr  = (apb_wr && paddr == uart_ic) ? pwdata[2:0] : 3'b000;
    assign irq_out = |(ip & ie);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_en     <= 1'b0;
            nstop     <= 1'b0;
            tx_th     <= '0;
            rx_en     <= 1'b0;
            rx_th     <= '0;
            ie        <= '0;
            div       <= uart_div_reset;
            parity_en <= 1'b0;
        end else if (apb_wr) begin
            case (paddr)
                uart_txctrl: begin
                    tx_en <= pwdata[0];
                    nstop <= pwdata[1];
                    tx_th <= pwdata[18:16];
                end
                uart_rxctrl: begin
                    rx_en <= pwdata[0];
                    rx_th <= pwdata[18:16];
                end
                uart_ie:  ie        <= pwdata[2:0];
                uart_div: div       <= pwdata[uart_div_width-1:0];
                uart_lcr: parity_en <= pwdata[0];
                default: ;
            endcase
        end
    end

    // A clear wins over a set in the sticky pending bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            ip <= '0;
        else
            ip <= (ip | {rx_perror, rx_above_th, tx_below_th}) & ~ip_clr;
    end

    always_comb begin
        rdata_mux = '0;
        case (paddr)
            uart_txfifo: rdata_mux = {tx_full, 31'b0};
            uart_rxfifo: rdata_mux = {rx_empty, 23'b0, rx_empty ? 8'b0 : rx_rdata};
            uart_txctrl: rdata_mux = {13'b0, tx_th, 14'b0, nstop, tx_en};
            uart_rxctrl: rdata_mux = {13'b0, rx_th, 15'b0, rx_en};
            uart_ie:     rdata_mux = {29'b0, ie};
            uart_ip:     rdata_mux = {29'b0, ip};
            uart_ic:     rdata_mux = {29'b0, ip};
            uart_div:    rdata_mux = {16'b0, div};
            uart_lcr:    rdata_mux = {31'b0, parity_en};
            default:     rdata_mux = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            prdata <= '0;
        else if (apb_rd)
            prdata <= rdata_mux;
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!rstn)
        penable |-> psel);

endmodule

//--- design/uart_apb_top.sv
`timescale 1ns/100ps

module uart_apb_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        irq_out,
    input  logic        uart_rx,
    output logic        uart_tx
);

    import uart_pkg::*;

    logic                       tx_push, tx_pop, tx_full, tx_empty, tx_below_th;
    logic                       rx_push, rx_pop, rx_empty, rx_above_th, rx_perror;
    logic [uart_data_width-1:0] tx_wdata, tx_rdata, rx_wdata, rx_rdata;
    logic                       tx_en, rx_en, nstop, parity_en;
    logic [uart_div_width-1:0]  div;
    logic [uart_th_width-1:0]   tx_th, rx_th;
    logic                       tx_timer_start, tx_tick;
    logic                       rx_timer_start, rx_tick, rx_mid;

    uart_regs u_regs (
        .clk, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .tx_push, .tx_wdata, .tx_full, .rx_pop, .rx_rdata,
        .rx_empty, .tx_below_th, .rx_above_th, .rx_perror, .tx_en, .rx_en,
        .nstop, .parity_en, .div, .tx_th, .rx_th, .irq_out
    );

    uart_fifo u_tx_fifo (
        .clk, .rstn, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop), .rdata(tx_rdata),
        .full(tx_full), .empty(tx_empty), .count(), .th(tx_th),
        .above_th(), .below_th(tx_below_th)
    );

    uart_fifo u_rx_fifo (
        .clk, .rstn, .push(rx_push), .wdata(rx_wdata), .pop(rx_pop), .rdata(rx_rdata),
        .full(), .empty(rx_empty), .count(), .th(rx_th),
        .above_th(rx_above_th), .below_th()
    );

    baud_timer u_tx_timer (
        .clk, .rstn, .start(tx_timer_start), .div, .tick(tx_tick), .mid()
    );

    baud_timer u_rx_timer (
        .clk, .rstn, .start(rx_timer_start), .div, .tick(rx_tick), .mid(rx_mid)
    );

    uart_tx_fsm u_tx_fsm (
        .clk, .rstn, .enable(tx_en), .parity_en, .nstop, .data_vld(!tx_empty),
        .data_in(tx_rdata), .pop(tx_pop), .tick(tx_tick),
        .timer_start(tx_timer_start), .uart_tx
    );

    uart_rx_fsm u_rx_fsm (
        .clk, .rstn, .enable(rx_en), .parity_en, .uart_rx, .tick(rx_tick),
        .mid(rx_mid), .timer_start(rx_timer_start), .push(rx_push),
        .data_out(rx_wdata), .perror(rx_perror)
    );

endmodule

//--- sim/uart_tb.sv
`timescale 1ns/100ps

module uart_tb;

    import uart_pkg::*;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq_out;
    logic        uart_rx;
    logic        uart_tx;

    integer      seed = 18625;
    int          errors;
    int          checks;
    logic [7:0]  tx_exp[$];
    logic [7:0]  tx_seen[$];
    logic [2:0]  m_ip;
    logic [2:0]  m_ie;
    int          tx_cnt;
    int          rx_cnt;
    int          tx_th;
    int          rx_th;
    int          cfg_div;
    logic        cfg_par;
    logic        cfg_nstop;

    uart_apb_top DUT (
        .clk, .rstn, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .irq_out, .uart_rx, .uart_tx
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // prdata is registered in the setup phase and held through the access phase
    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_reg(input logic [11:0] addr, input logic [31:0] exp_v,
                              input string what);
        logic [31:0] got;
        apb_read(addr, got);
        checks++;
        if (got !== exp_v) begin
            errors++;
            $display("error @%0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp_v);
        end
    endtask

    // Watermark sources are levels, so a pending bit sets whenever its compare holds
    task automatic refresh_model_ip();
        if (tx_cnt <= tx_th)
            m_ip[0] = 1'b1;
        if (rx_cnt > rx_th)
            m_ip[1] = 1'b1;
    endtask

    task automatic clear_pending(input logic [2:0] mask);
        apb_write(uart_ic, {29'b0, mask});
        m_ip = m_ip & ~mask;
        refresh_model_ip();
    endtask

    task automatic check_pending();
        expect_reg(uart_ip, {29'b0, m_ip}, "ip");
        @(negedge clk);
        checks++;
        if (irq_out !== |(m_ip & m_ie)) begin
            errors++;
            $display("error @%0t: irq_out is %b, expected %b", $time, irq_out,
                     |(m_ip & m_ie));
        end
    endtask

    task automatic set_tx_ctrl(input logic en, input logic ns, input logic [2:0] th);
        apb_write(uart_txctrl, {13'b0, th, 14'b0, ns, en});
        cfg_nstop = ns;
        tx_th     = th;
        refresh_model_ip();
    endtask

    task automatic set_rx_ctrl(input logic en, input logic [2:0] th);
        apb_write(uart_rxctrl, {13'b0, th, 15'b0, en});
        rx_th = th;
        refresh_model_ip();
    endtask

    // Start, data LSB first, optional parity, stop bits, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic bad_par);
        logic [12:0] bits;
        int          nbits;
        bits  = {4'b1111, data, 1'b0};
        nbits = 11 + cfg_par + cfg_nstop;
        if (cfg_par)
            bits[9] = ^data ^ bad_par;
        @(posedge clk);
        for (int i = 0; i < nbits; i++) begin
            uart_rx <= bits[i];
            repeat (cfg_div + 1) @(posedge clk);
        end
    endtask

    task automatic drain_tx_check();
        int         tmo;
        logic [7:0] exp_b;
        logic [7:0] got_b;
        tmo = 0;
        while (tx_seen.size() < tx_exp.size() && tmo < 20000) begin
            @(posedge clk);
            tmo++;
        end
        if (tx_seen.size() < tx_exp.size()) begin
            errors++;
            $display("transmitter timed out with %0d of %0d bytes sent",
                     tx_seen.size(), tx_exp.size());
        end
        while (tx_exp.size() > 0 && tx_seen.size() > 0) begin
            exp_b = tx_exp.pop_front();
            got_b = tx_seen.pop_front();
            checks++;
            if (got_b !== exp_b) begin
                errors++;
                $display("error @%0t: uart_tx sent 0x%02h, expected 0x%02h",
                         $time, got_b, exp_b);
            end
        end
        tx_exp.delete();
        // Nothing else may show up within one more frame
        repeat (14 * (cfg_div + 1)) @(posedge clk);
        if (tx_seen.size() != 0) begin
            errors++;
            $display("error @%0t: uart_tx sent %0d unexpected bytes", $time, tx_seen.size());
            tx_seen.delete();
        end
        tx_cnt = 0;
        refresh_model_ip();
    endtask

    // Serial monitor on uart_tx that samples every negedge of each bit slot
    always begin : tx_monitor
        logic [12:0] bits;
        logic [7:0]  data;
        int          nbits;
        logic        stop_bad;
        @(negedge clk);
        if (rstn && uart_tx === 1'b0) begin
            nbits    = 10 + cfg_par + cfg_nstop;
            stop_bad = 1'b0;
            for (int b = 0; b < nbits; b++) begin
                for (int j = 0; j <= cfg_div; j++) begin
                    if (b > 0 || j > 0)
                        @(negedge clk);
                    if (j == (cfg_div + 1) / 2)
                        bits[b] = uart_tx;
                    if (b >= nbits - 1 - cfg_nstop && uart_tx !== 1'b1)
                        stop_bad = 1'b1;
                end
            end
            data = bits[8:1];
            checks++;
            if (bits[0] !== 1'b0 || stop_bad) begin
                errors++;
                $display("error @%0t: frame of 0x%02h has a bad start or stop bit", $time, data);
            end
            if (cfg_par && bits[9] !== ^data) begin
                errors++;
                $display("error @%0t: parity bit of 0x%02h is %b, expected %b",
                         $time, data, bits[9], ^data);
            end
            tx_seen.push_back(data);
        end
    end

    initial begin : main
        logic [31:0] val;
        logic [7:0]  rx_exp[$];
        logic [11:0] rb_addr[5];
        logic [31:0] rb_mask[5];
        int          n;

        rstn      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        uart_rx   = 1'b1;
        errors    = 0;
        checks    = 0;
        m_ip      = '0;
        m_ie      = '0;
        tx_cnt    = 0;
        rx_cnt    = 0;
        tx_th     = 0;
        rx_th     = 0;
        cfg_div   = 433;
        cfg_par   = 1'b0;
        cfg_nstop = 1'b0;
        rb_addr   = '{uart_txctrl, uart_rxctrl, uart_ie, uart_div, uart_lcr};
        rb_mask   = '{32'h0007_0003, 32'h0007_0001, 32'h7, 32'hFFFF, 32'h1};

        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        refresh_model_ip();
        @(negedge clk);
        checks++;
        if (irq_out !== 1'b0 || uart_tx !== 1'b1 || pready !== 1'b1 || pslverr !== 1'b0) begin
            errors++;
            $display("error @%0t: outputs after reset irq_out %b uart_tx %b pready %b pslverr %b",
                     $time, irq_out, uart_tx, pready, pslverr);
        end

        // Reset values
        expect_reg(uart_txfifo, 32'h0, "txfifo");
        expect_reg(uart_rxfifo, 32'h8000_0000, "rxfifo");
        expect_reg(uart_txctrl, 32'h0, "txctrl");
        expect_reg(uart_rxctrl, 32'h0, "rxctrl");
        expect_reg(uart_ie, 32'h0, "ie");
        expect_reg(uart_ip, {29'b0, m_ip}, "ip");
        expect_reg(uart_ic, {29'b0, m_ip}, "ic");
        expect_reg(uart_div, 32'd433, "div");
        expect_reg(uart_lcr, 32'h0, "lcr");

        for (int i = 0; i < 5; i++) begin
            val = $random(seed);
            apb_write(rb_addr[i], val);
            expect_reg(rb_addr[i], val & rb_mask[i], "readback");
        end
        set_tx_ctrl(1'b0, 1'b0, 3'd0);
        set_rx_ctrl(1'b0, 3'd0);
        apb_write(uart_ie, 32'h0);
        apb_write(uart_lcr, 32'h0);
        val     = $random(seed);
        cfg_div = 3 + val[15:0] % 7;
        apb_write(uart_div, cfg_div);

        // Transmit under random frame formats
        for (int r = 0; r < 4; r++) begin
            val     = $random(seed);
            cfg_par = val[0];
            apb_write(uart_lcr, {31'b0, cfg_par});
            set_tx_ctrl(1'b1, val[1], val[18:16]);
            n = 2 + val[9:8] % 3;
            for (int i = 0; i < n; i++) begin
                val = $random(seed);
                tx_exp.push_back(val[7:0]);
                apb_write(uart_txfifo, {24'b0, val[7:0]});
            end
            drain_tx_check();
        end

        // TX FIFO fill with the transmitter off, then the TX watermark
        val = $random(seed);
        set_tx_ctrl(1'b0, cfg_nstop, val[2:0]);
        apb_write(uart_txfifo, 32'h8000_00A5);
        clear_pending(3'b001);
        check_pending();
        for (int i = 0; i < 9; i++) begin
            val = $random(seed);
            apb_write(uart_txfifo, {24'b0, val[7:0]});
            if (i < 8) begin
                tx_exp.push_back(val[7:0]);
                tx_cnt++;
            end
            refresh_model_ip();
            check_pending();
            clear_pending(3'b001);
        end
        expect_reg(uart_txfifo, 32'h8000_0000, "txfifo full flag");
        set_tx_ctrl(1'b1, cfg_nstop, tx_th);
        drain_tx_check();

        // Receive with the RX watermark
        val     = $random(seed);
        cfg_par = val[0];
        m_ie    = val[14:12];
        apb_write(uart_lcr, {31'b0, cfg_par});
        apb_write(uart_ie, {29'b0, m_ie});
        set_rx_ctrl(1'b1, val[6:4]);
        clear_pending(3'b010);
        n = 3 + val[10:8] % 6;
        for (int i = 0; i < n; i++) begin
            val = $random(seed);
            rx_exp.push_back(val[7:0]);
            send_frame(val[7:0], 1'b0);
            rx_cnt++;
            refresh_model_ip();
            check_pending();
        end
        clear_pending(3'b010);
        check_pending();
        while (rx_exp.size() > 0) begin
            expect_reg(uart_rxfifo, {24'b0, rx_exp.pop_front()}, "rxfifo data");
            rx_cnt--;
        end
        expect_reg(uart_rxfifo, 32'h8000_0000, "rxfifo drained");
        check_pending();

        // Wrong parity bit raises irq only when enabled
        cfg_par = 1'b1;
        apb_write(uart_lcr, 32'h1);
        for (int k = 0; k < 2; k++) begin
            m_ie = (k == 1) ? 3'b100 : 3'b000;
            apb_write(uart_ie, {29'b0, m_ie});
            clear_pending(3'b111);
            check_pending();
            val = $random(seed);
            send_frame(val[7:0], 1'b1);
            m_ip[2] = 1'b1;
            check_pending();
            expect_reg(uart_rxfifo, 32'h8000_0000, "rxfifo after parity error");
            clear_pending(3'b100);
            check_pending();
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb.f
design/uart_pkg.sv
design/uart_fifo.sv
design/baud_timer.sv
design/uart_tx_fsm.sv
design/uart_rx_fsm.sv
design/uart_regs.sv
design/uart_apb_top.sv
sim/uart_tb.sv

//--- Bender.yml
package:
  name: uart_apb

sources:
  - files:
      - design/uart_pkg.sv
      - design/uart_fifo.sv
      - design/baud_timer.sv
      - design/uart_tx_fsm.sv
      - design/uart_rx_fsm.sv
      - design/uart_regs.sv
      - design/uart_apb_top.sv
  - target: simulation
    files:
      - sim/uart_tb.sv
